// ==== hw/fetch_settings.svh ====
`ifndef FETCH_SETTINGS_SVH
`define FETCH_SETTINGS_SVH

// Width of the PC and of all fetch addresses.
`define XLEN 64

// First PC fetched once reset is released.
`define RESET_VECTOR 64'h0000_0000_0000_1000

// Static branch prediction on (1) or off (0).
`define BRANCH_PRED 1'b1

// Address width of the AXI4-Lite read port.
`define AXI_ADDR_W 32

`endif

// ==== hw/fetch_pkg.sv ====
`include "fetch_settings.svh"

package fetch_pkg;

    typedef enum logic [2:0] {
        IF_RESET,
        IF_PREFETCH,
        IF_PREDICT,
        IF_MISPREDICT,
        IF_FENCE_I,
        IF_TRAP
    } if_reason_t;

    typedef struct packed {
        logic             valid;
        logic [3:0]       mcause_code;
        logic [`XLEN-1:0] mtval;
    } exception_t;

    // Fetcher to aligner.
    typedef struct packed {
        logic [`XLEN-1:0] pc;
        if_reason_t       reason;
    } fetch_req_t;

    // Aligner to fetcher.
    typedef struct packed {
        logic [31:0]      instr_word;
        logic [`XLEN-1:0] pc;
        logic             error;
    } fetch_resp_t;

    // Item handed to decode.
    typedef struct packed {
        logic [31:0]      instr_word;
        logic [`XLEN-1:0] pc;
        if_reason_t       if_reason;
        exception_t       exception;
    } fetched_instr_t;

    // Byte address of a 32-bit word, low two bits zero.
    typedef struct packed {
        logic [`AXI_ADDR_W-1:0] addr;
    } word_req_t;

    typedef struct packed {
        logic [31:0] data;
        logic        error;
    } word_resp_t;

endpackage

// ==== hw/axil_fetch_port.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module axil_fetch_port import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   i_req_valid,
    output logic                   o_req_ready,
    input  word_req_t              i_req,
    input  logic                   i_abort,
    output logic                   o_resp_valid,
    output word_resp_t             o_resp,

    output logic [`AXI_ADDR_W-1:0] o_araddr,
    output logic [2:0]             o_arprot,
    output logic                   o_arvalid,
    input  logic                   i_arready,
    input  logic [31:0]            i_rdata,
    input  logic [1:0]             i_rresp,
    input  logic                   i_rvalid,
    output logic                   o_rready
);

    typedef enum logic [1:0] {
        P_IDLE,
        P_ADDR,
        P_DATA
    } port_state_t;

    port_state_t            state;
    logic                   drop;
    logic [`AXI_ADDR_W-1:0] araddr_q;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state <= P_IDLE;
            drop  <= 1'b0;
        end else begin
            case (state)
                P_IDLE: begin
                    if (i_req_valid) begin
                        state <= P_ADDR;
                        drop  <= 1'b0;
                    end
                end
                P_ADDR: begin
                    if (i_arready) begin
                        state <= P_DATA;
                    end
                    // The AR beat cannot be withdrawn, so only the data is dropped.
                    if (i_abort) begin
                        drop <= 1'b1;
                    end
                end
                P_DATA: begin
                    if (i_rvalid) begin
                        state <= P_IDLE;
                        drop  <= 1'b0;
                    end else if (i_abort) begin
                        drop <= 1'b1;
                    end
                end
                default: begin
                    state <= P_IDLE;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == P_IDLE && i_req_valid) begin
            araddr_q <= i_req.addr;
        end
    end

    assign o_req_ready = (state == P_IDLE);

    assign o_araddr  = araddr_q;
    // Unprivileged, secure, instruction access.
    assign o_arprot  = 3'b100;
    assign o_arvalid = (state == P_ADDR);
    assign o_rready  = (state == P_DATA);

    assign o_resp_valid = (state == P_DATA) && i_rvalid && !drop && !i_abort;
    assign o_resp.data  = i_rdata;
    // Anything but OKAY is an error.
    assign o_resp.error = (i_rresp != 2'b00);

endmodule

// ==== hw/instr_align.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module instr_align import fetch_pkg::*; (
    input  logic        clk,
    input  logic        resetn,

    input  logic        i_req_valid,
    input  fetch_req_t  i_req,
    input  logic        i_flush,
    output logic        o_resp_valid,
    output fetch_resp_t o_resp,

    output logic        o_wreq_valid,
    input  logic        i_wreq_ready,
    output word_req_t   o_wreq,
    output logic        o_abort,
    input  logic        i_wresp_valid,
    input  word_resp_t  i_wresp
);

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOK,
        S_LO_REQ,
        S_LO_WAIT,
        S_HI_REQ,
        S_HI_WAIT
    } align_state_t;

    align_state_t     state;
    logic [`XLEN-1:0] pc_q;
    logic [15:0]      lo_half;

    // One-word line buffer.
    logic             line_valid;
    logic [`XLEN-3:0] line_tag;
    logic [31:0]      line_data;

    logic             lo_hit;
    logic [15:0]      half_at_pc;
    logic             is_long;
    logic             straddle;
    logic             fill;

    assign lo_hit     = line_valid && (line_tag == pc_q[`XLEN-1:2]);
    assign half_at_pc = pc_q[1] ? line_data[31:16] : line_data[15:0];
    assign is_long    = (half_at_pc[1:0] == 2'b11);
    // Upper halfword lives in the next word.
    assign straddle   = is_long && pc_q[1];
    assign fill       = i_wresp_valid && !i_wresp.error
                        && (state == S_LO_WAIT || state == S_HI_WAIT);

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            state      <= S_IDLE;
            line_valid <= 1'b0;
        end else begin
            if (i_flush) begin
                state <= S_IDLE;
            end else if (i_req_valid) begin
                state <= S_LOOK;
            end else begin
                case (state)
                    S_LOOK: begin
                        if (!lo_hit) begin
                            state <= S_LO_REQ;
                        end else begin
                            state <= straddle ? S_HI_REQ : S_IDLE;
                        end
                    end
                    S_LO_REQ:  if (i_wreq_ready) state <= S_LO_WAIT;
                    S_HI_REQ:  if (i_wreq_ready) state <= S_HI_WAIT;
                    S_LO_WAIT: begin
                        // After a good fill the lookup is simply repeated.
                        if (i_wresp_valid) begin
                            state <= i_wresp.error ? S_IDLE : S_LOOK;
                        end
                    end
                    S_HI_WAIT: if (i_wresp_valid) state <= S_IDLE;
                    default:   state <= S_IDLE;
                endcase
            end

            if (i_req_valid && i_req.reason == IF_FENCE_I) begin
                line_valid <= 1'b0;
            end else if (fill) begin
                line_valid <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (i_req_valid) begin
            pc_q <= i_req.pc;
        end
        if (state == S_LOOK && lo_hit && straddle) begin
            lo_half <= half_at_pc;
        end
        if (fill) begin
            line_data <= i_wresp.data;
            line_tag  <= (state == S_HI_WAIT) ? pc_q[`XLEN-1:2] + 1'b1 : pc_q[`XLEN-1:2];
        end
    end

    assign o_wreq_valid = (state == S_LO_REQ || state == S_HI_REQ) && !i_flush;
    assign o_wreq.addr  = (state == S_HI_REQ) ? {pc_q[`AXI_ADDR_W-1:2] + 1'b1, 2'b00}
                                              : {pc_q[`AXI_ADDR_W-1:2], 2'b00};
    assign o_abort      = i_flush;

    always_comb begin
        o_resp_valid = 1'b0;
        o_resp.pc    = pc_q;
        o_resp.error = 1'b0;
        if (is_long && !pc_q[1]) begin
            o_resp.instr_word = line_data;
        end else begin
            o_resp.instr_word = {16'h0000, half_at_pc};
        end

        case (state)
            S_LOOK: begin
                o_resp_valid = lo_hit && !straddle;
            end
            S_LO_WAIT: begin
                // Only a failed read answers from here.
                o_resp_valid      = i_wresp_valid && i_wresp.error;
                o_resp.error      = 1'b1;
                o_resp.instr_word = '0;
            end
            S_HI_WAIT: begin
                o_resp_valid      = i_wresp_valid;
                o_resp.error      = i_wresp.error;
                o_resp.instr_word = {i_wresp.data[15:0], lo_half};
            end
            default: begin
                o_resp_valid = 1'b0;
            end
        endcase

        if (i_flush) begin
            o_resp_valid = 1'b0;
        end
    end

endmodule

// ==== hw/instr_fetcher.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module instr_fetcher import fetch_pkg::*; (
    input  logic             clk,
    input  logic             resetn,

    input  logic             i_redirect_valid,
    input  logic [`XLEN-1:0] i_redirect_pc,
    input  if_reason_t       i_redirect_reason,

    output logic             o_req_valid,
    output fetch_req_t       o_req,
    output logic             o_flush,
    input  logic             i_resp_valid,
    input  fetch_resp_t      i_resp,

    output logic             o_valid,
    input  logic             i_ready,
    output fetched_instr_t   o_fetched_instr
);

    // Next PC to fetch. Starts pending so the first fetch goes out after reset.
    logic             pend_valid;
    logic [`XLEN-1:0] pend_pc;
    if_reason_t       pend_reason;

    logic             outstanding;
    if_reason_t       cur_reason;

    // Response parked while decode is stalled.
    logic             held;
    logic [31:0]      hold_word;
    logic [`XLEN-1:0] hold_pc;
    logic             hold_err;

    logic [31:0]      word;
    logic [`XLEN-1:0] pc;
    logic             err;
    logic             transfer;

    logic             is_branch;
    logic             is_jal;
    logic             is_c_branch;
    logic             is_c_j;
    logic [`XLEN-1:0] b_imm;
    logic [`XLEN-1:0] j_imm;
    logic [`XLEN-1:0] cb_imm;
    logic [`XLEN-1:0] cj_imm;
    logic             predict_taken;
    logic [`XLEN-1:0] predict_target;
    logic [`XLEN-1:0] pc_next;
    if_reason_t       reason_next;

    assign o_req_valid = pend_valid && !outstanding && !held && !i_redirect_valid;
    assign o_req.pc     = pend_pc;
    assign o_req.reason = pend_reason;
    assign o_flush      = i_redirect_valid;

    assign o_valid  = (held || i_resp_valid) && !i_redirect_valid;
    assign transfer = o_valid && i_ready;

    assign word = held ? hold_word : i_resp.instr_word;
    assign pc   = held ? hold_pc : i_resp.pc;
    assign err  = held ? hold_err : i_resp.error;

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            pend_valid  <= 1'b1;
            pend_pc     <= `RESET_VECTOR;
            pend_reason <= IF_RESET;
            outstanding <= 1'b0;
            held        <= 1'b0;
        end else begin
            if (i_redirect_valid) begin
                pend_valid  <= 1'b1;
                pend_pc     <= {i_redirect_pc[`XLEN-1:1], 1'b0};
                pend_reason <= i_redirect_reason;
            end else if (transfer) begin
                pend_valid  <= 1'b1;
                pend_pc     <= pc_next;
                pend_reason <= reason_next;
            end else if (o_req_valid) begin
                pend_valid <= 1'b0;
            end

            if (i_redirect_valid) begin
                outstanding <= 1'b0;
            end else if (o_req_valid) begin
                outstanding <= 1'b1;
            end else if (i_resp_valid) begin
                outstanding <= 1'b0;
            end

            if (i_redirect_valid) begin
                held <= 1'b0;
            end else if (i_resp_valid && !i_ready) begin
                held <= 1'b1;
            end else if (i_ready) begin
                held <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (o_req_valid) begin
            cur_reason <= pend_reason;
        end
        if (i_resp_valid && !i_ready) begin
            hold_word <= i_resp.instr_word;
            hold_pc   <= i_resp.pc;
            hold_err  <= i_resp.error;
        end
    end

    assign o_fetched_instr.instr_word            = word;
    assign o_fetched_instr.pc                    = pc;
    assign o_fetched_instr.if_reason             = cur_reason;
    assign o_fetched_instr.exception.valid       = err;
    // Instruction access fault.
    assign o_fetched_instr.exception.mcause_code = 4'd1;
    assign o_fetched_instr.exception.mtval       = pc;

    // Static prediction, backward taken and forward not taken.
    assign is_branch   = (word[6:0] == 7'b1100011);
    assign is_jal      = (word[6:0] == 7'b1101111);
    assign is_c_branch = (word[1:0] == 2'b01) && (word[15:14] == 2'b11);
    assign is_c_j      = (word[1:0] == 2'b01) && (word[15:13] == 3'b101);

    assign b_imm  = {{(`XLEN-13){word[31]}}, word[31], word[7], word[30:25],
                     word[11:8], 1'b0};
    assign j_imm  = {{(`XLEN-21){word[31]}}, word[31], word[19:12], word[20],
                     word[30:21], 1'b0};
    assign cb_imm = {{(`XLEN-9){word[12]}}, word[12], word[6:5], word[2],
                     word[11:10], word[4:3], 1'b0};
    assign cj_imm = {{(`XLEN-12){word[12]}}, word[12], word[8], word[10:9], word[6],
                     word[7], word[2], word[11], word[5:3], 1'b0};

    always_comb begin
        predict_taken  = 1'b0;
        predict_target = pc + b_imm;
        if (`BRANCH_PRED) begin
            if (is_branch) begin
                predict_taken = word[31];
            end else if (is_jal) begin
                predict_taken  = 1'b1;
                predict_target = pc + j_imm;
            end else if (is_c_branch) begin
                predict_taken  = word[12];
                predict_target = pc + cb_imm;
            end else if (is_c_j) begin
                predict_taken  = 1'b1;
                predict_target = pc + cj_imm;
            end
        end
    end

    always_comb begin
        if (predict_taken) begin
            pc_next     = predict_target;
            reason_next = IF_PREDICT;
        end else begin
            pc_next     = pc + ((word[1:0] == 2'b11) ? `XLEN'd4 : `XLEN'd2);
            reason_next = IF_PREFETCH;
        end
    end

endmodule

// ==== hw/fetch_top.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module fetch_top import fetch_pkg::*; (
    input  logic                   clk,
    input  logic                   resetn,

    input  logic                   i_redirect_valid,
    input  logic [`XLEN-1:0]       i_redirect_pc,
    input  if_reason_t             i_redirect_reason,

    output logic                   o_valid,
    input  logic                   i_ready,
    output fetched_instr_t         o_fetched_instr,

    output logic [`AXI_ADDR_W-1:0] o_araddr,
    output logic [2:0]             o_arprot,
    output logic                   o_arvalid,
    input  logic                   i_arready,
    input  logic [31:0]            i_rdata,
    input  logic [1:0]             i_rresp,
    input  logic                   i_rvalid,
    output logic                   o_rready
);

    logic        req_valid;
    fetch_req_t  req;
    logic        flush;
    logic        resp_valid;
    fetch_resp_t resp;

    logic        wreq_valid;
    logic        wreq_ready;
    word_req_t   wreq;
    logic        abort;
    logic        wresp_valid;
    word_resp_t  wresp;

    instr_fetcher u_fetcher (
        .clk               (clk),
        .resetn            (resetn),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_pc     (i_redirect_pc),
        .i_redirect_reason (i_redirect_reason),
        .o_req_valid       (req_valid),
        .o_req             (req),
        .o_flush           (flush),
        .i_resp_valid      (resp_valid),
        .i_resp            (resp),
        .o_valid           (o_valid),
        .i_ready           (i_ready),
        .o_fetched_instr   (o_fetched_instr)
    );

    instr_align u_align (
        .clk           (clk),
        .resetn        (resetn),
        .i_req_valid   (req_valid),
        .i_req         (req),
        .i_flush       (flush),
        .o_resp_valid  (resp_valid),
        .o_resp        (resp),
        .o_wreq_valid  (wreq_valid),
        .i_wreq_ready  (wreq_ready),
        .o_wreq        (wreq),
        .o_abort       (abort),
        .i_wresp_valid (wresp_valid),
        .i_wresp       (wresp)
    );

    axil_fetch_port u_port (
        .clk          (clk),
        .resetn       (resetn),
        .i_req_valid  (wreq_valid),
        .o_req_ready  (wreq_ready),
        .i_req        (wreq),
        .i_abort      (abort),
        .o_resp_valid (wresp_valid),
        .o_resp       (wresp),
        .o_araddr     (o_araddr),
        .o_arprot     (o_arprot),
        .o_arvalid    (o_arvalid),
        .i_arready    (i_arready),
        .i_rdata      (i_rdata),
        .i_rresp      (i_rresp),
        .i_rvalid     (i_rvalid),
        .o_rready     (o_rready)
    );

endmodule

// ==== tb/axil_rom_model.sv ====
`timescale 1ns/10ps

module axil_rom_model (
    input  logic        clk,
    input  logic        resetn,

    input  logic [31:0] i_araddr,
    input  logic        i_arvalid,
    output logic        o_arready,
    output logic [31:0] o_rdata,
    output logic [1:0]  o_rresp,
    output logic        o_rvalid,
    input  logic        i_rready
);

    localparam int          WORDS    = 32;
    localparam logic [31:0] BASE     = 32'h0000_1000;
    localparam logic [31:0] ERR_ADDR = 32'h0000_1040;

    logic [31:0] program_mem [WORDS];
    logic        busy;
    logic [1:0]  wait_q;
    logic [31:0] addr_q;
    logic [31:0] rng;
    logic        in_range;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    // Rotated address mixed into an addi opcode.
    function automatic logic [31:0] fill_word(input logic [31:0] addr);
        return 32'h0000_0013 ^ {addr[24:0], addr[31:25]};
    endfunction

    initial begin
        for (int i = 0; i < WORDS; i++) begin
            program_mem[i] = fill_word(BASE + 32'(i * 4));
        end
        program_mem[0]  = 32'h8093_0085;
        program_mem[1]  = 32'h0001_0010;
        program_mem[2]  = 32'h0021_0113;
        program_mem[3]  = 32'h0000_0463;
        program_mem[4]  = 32'h0100_006F;
        program_mem[8]  = 32'h0001_A021;
        program_mem[9]  = 32'h00C0_006F;
        program_mem[10] = 32'h0001_FC75;
        program_mem[11] = 32'h0080_006F;
        program_mem[12] = 32'hFE00_0EE3;
        program_mem[13] = 32'h0010_8093;
        program_mem[14] = 32'h0021_0113;
        program_mem[15] = 32'h0010_8093;
        program_mem[20] = 32'h0001_0085;
        program_mem[21] = 32'h0021_0113;
    end

    always_ff @(posedge clk or negedge resetn) begin
        if (!resetn) begin
            busy     <= 1'b0;
            wait_q   <= 2'd0;
            addr_q   <= 32'h0;
            o_rvalid <= 1'b0;
            rng      <= 32'h3842_7307;
        end else if (!busy) begin
            if (i_arvalid) begin
                busy   <= 1'b1;
                addr_q <= i_araddr;
                wait_q <= rng[1:0];
                rng    <= next_random(rng);
            end
        end else if (!o_rvalid) begin
            if (wait_q == 2'd0) begin
                o_rvalid <= 1'b1;
            end else begin
                wait_q <= wait_q - 2'd1;
            end
        end else if (i_rready) begin
            o_rvalid <= 1'b0;
            busy     <= 1'b0;
        end
    end

    assign o_arready = !busy;
    assign in_range  = (addr_q >= BASE) && (addr_q < BASE + 32'(WORDS * 4));
    assign o_rdata   = in_range ? program_mem[addr_q[6:2]] : fill_word(addr_q);
    // SLVERR for the one faulting word.
    assign o_rresp   = (addr_q == ERR_ADDR) ? 2'b10 : 2'b00;

endmodule

// ==== tb/tb_fetch_top.sv ====
`timescale 1ns/10ps
`include "fetch_settings.svh"

module tb_fetch_top import fetch_pkg::*; ();

    typedef struct packed {
        logic             redir;
        logic [`XLEN-1:0] redir_pc;
        if_reason_t       redir_reason;
        logic [`XLEN-1:0] pc;
        logic [31:0]      instr;
        if_reason_t       reason;
        logic             exc;
    } row_t;

    logic                   clk = 1'b0;
    logic                   resetn;
    logic                   i_redirect_valid;
    logic [`XLEN-1:0]       i_redirect_pc;
    if_reason_t             i_redirect_reason;
    logic                   o_valid;
    logic                   i_ready;
    fetched_instr_t         o_fetched_instr;
    logic [`AXI_ADDR_W-1:0] araddr;
    logic [2:0]             arprot;
    logic                   arvalid;
    logic                   arready;
    logic [31:0]            rdata;
    logic [1:0]             rresp;
    logic                   rvalid;
    logic                   rready;

    row_t           expected[$];
    int             cycles = 0;
    logic [31:0]    rng = 32'h3842_7307;

    fetch_top DUT (
        .clk               (clk),
        .resetn            (resetn),
        .i_redirect_valid  (i_redirect_valid),
        .i_redirect_pc     (i_redirect_pc),
        .i_redirect_reason (i_redirect_reason),
        .o_valid           (o_valid),
        .i_ready           (i_ready),
        .o_fetched_instr   (o_fetched_instr),
        .o_araddr          (araddr),
        .o_arprot          (arprot),
        .o_arvalid         (arvalid),
        .i_arready         (arready),
        .i_rdata           (rdata),
        .i_rresp           (rresp),
        .i_rvalid          (rvalid),
        .o_rready          (rready)
    );

    axil_rom_model u_rom (
        .clk       (clk),
        .resetn    (resetn),
        .i_araddr  (araddr),
        .i_arvalid (arvalid),
        .o_arready (arready),
        .o_rdata   (rdata),
        .o_rresp   (rresp),
        .o_rvalid  (rvalid),
        .i_rready  (rready)
    );

    always #10 clk = ~clk;

    function automatic logic [31:0] next_random(input logic [31:0] x);
        logic [31:0] s;
        s = x ^ (x << 13);
        s = s ^ (s >> 17);
        s = s ^ (s << 5);
        return s;
    endfunction

    function automatic row_t make_row(input logic [`XLEN-1:0] pc, input logic [31:0] instr,
                                      input if_reason_t reason, input logic exc);
        row_t r;
        r              = '0;
        r.redir_reason = IF_RESET;
        r.pc           = pc;
        r.instr        = instr;
        r.reason       = reason;
        r.exc          = exc;
        return r;
    endfunction

    task automatic expect_equal(input logic [$bits(fetched_instr_t)-1:0] got,
                                input logic [$bits(fetched_instr_t)-1:0] exp,
                                input string what);
        if (got !== exp) begin
            $display("FAIL %0t: %s is %0h, expected %0h", $time, what, got, exp);
            $display("TEST FAILED");
            $fatal(1, "Mismatch on %s", what);
        end
    endtask

    // Run limit scales with the number of expected items.
    always @(posedge clk) begin
        if (resetn) begin
            cycles <= cycles + 1;
            if (cycles > 40 * expected.size()) begin
                $display("Timeout: the fetch unit stopped handing out instructions");
                $display("TEST FAILED");
                $fatal(1, "Run exceeded its cycle limit");
            end
        end
    end

    initial begin
        row_t           r;
        fetched_instr_t stall_item;
        logic           stall_seen;
        logic           moved;
        int             idx;
        int             countdown;

        resetn            = 1'b0;
        i_redirect_valid  = 1'b0;
        i_redirect_pc     = '0;
        i_redirect_reason = IF_RESET;
        i_ready           = 1'b0;

        expected.push_back(make_row(64'h1000, 32'h0000_0085, IF_RESET, 1'b0));
        // Straddles the 0x1000 and 0x1004 words.
        expected.push_back(make_row(64'h1002, 32'h0010_8093, IF_PREFETCH, 1'b0));
        expected.push_back(make_row(64'h1006, 32'h0000_0001, IF_PREFETCH, 1'b0));
        expected.push_back(make_row(64'h1008, 32'h0021_0113, IF_PREFETCH, 1'b0));
        // Forward beq is not taken.
        expected.push_back(make_row(64'h100C, 32'h0000_0463, IF_PREFETCH, 1'b0));
        expected.push_back(make_row(64'h1010, 32'h0100_006F, IF_PREFETCH, 1'b0));
        expected.push_back(make_row(64'h1020, 32'h0000_A021, IF_PREDICT, 1'b0));
        expected.push_back(make_row(64'h1028, 32'h0000_FC75, IF_PREDICT, 1'b0));
        expected.push_back(make_row(64'h1024, 32'h00C0_006F, IF_PREDICT, 1'b0));
        expected.push_back(make_row(64'h1030, 32'hFE00_0EE3, IF_PREDICT, 1'b0));
        expected.push_back(make_row(64'h102C, 32'h0080_006F, IF_PREDICT, 1'b0));
        expected.push_back(make_row(64'h1034, 32'h0010_8093, IF_PREDICT, 1'b0));
        expected.push_back(make_row(64'h1038, 32'h0021_0113, IF_PREFETCH, 1'b0));
        expected.push_back(make_row(64'h103C, 32'h0010_8093, IF_PREFETCH, 1'b0));
        expected.push_back(make_row(64'h1040, 32'h0000_0000, IF_PREFETCH, 1'b1));
        r              = make_row(64'h1050, 32'h0000_0085, IF_MISPREDICT, 1'b0);
        r.redir        = 1'b1;
        r.redir_pc     = 64'h1051;
        r.redir_reason = IF_MISPREDICT;
        expected.push_back(r);
        expected.push_back(make_row(64'h1052, 32'h0000_0001, IF_PREFETCH, 1'b0));
        expected.push_back(make_row(64'h1054, 32'h0021_0113, IF_PREFETCH, 1'b0));

        repeat (2) @(posedge clk);
        resetn <= 1'b1;
        @(posedge clk);
        expect_equal(o_valid, 1'b0, "o_valid after reset");

        idx        = 0;
        countdown  = 0;
        stall_seen = 1'b0;
        stall_item = '0;
        while (idx < expected.size()) begin
            @(posedge clk);
            // Every AR beat is an instruction fetch.
            if (arvalid) begin
                expect_equal(arprot[2], 1'b1, "arprot instruction bit");
            end
            // A stalled item must not change until it transfers.
            if (stall_seen && !i_redirect_valid) begin
                expect_equal(o_valid, 1'b1, "o_valid under back-pressure");
                expect_equal(o_fetched_instr, stall_item, "held item");
            end
            moved = o_valid && i_ready && !i_redirect_valid;
            if (moved) begin
                r = expected[idx];
                expect_equal(o_fetched_instr.pc, r.pc, "pc");
                expect_equal(o_fetched_instr.instr_word, r.instr, "instr_word");
                expect_equal(o_fetched_instr.if_reason, r.reason, "if_reason");
                expect_equal(o_fetched_instr.exception.valid, r.exc, "exception valid");
                expect_equal(o_fetched_instr.exception.mcause_code, 4'd1, "mcause code");
                expect_equal(o_fetched_instr.exception.mtval, r.pc, "mtval");
                idx++;
            end
            stall_seen = o_valid && !i_ready && !i_redirect_valid;
            stall_item = o_fetched_instr;

            i_redirect_valid <= 1'b0;
            rng = next_random(rng);
            if (countdown > 0) begin
                countdown--;
                if (countdown == 0) begin
                    r = expected[idx];
                    i_redirect_valid  <= 1'b1;
                    i_redirect_pc     <= r.redir_pc;
                    i_redirect_reason <= r.redir_reason;
                    i_ready           <= (rng[1:0] != 2'b00);
                end else begin
                    i_ready <= 1'b0;
                end
            end else if (moved && idx < expected.size() && expected[idx].redir) begin
                // Let the next read get onto the bus before redirecting.
                countdown = 3;
                i_ready <= 1'b0;
            end else begin
                i_ready <= (rng[1:0] != 2'b00);
            end
        end

        $display("TEST PASSED");
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+hw
hw/fetch_pkg.sv
hw/axil_fetch_port.sv
hw/instr_align.sv
hw/instr_fetcher.sv
hw/fetch_top.sv
tb/axil_rom_model.sv
tb/tb_fetch_top.sv

// ==== Bender.yml ====
package:
  name: fetch_frontend

sources:
  - include_dirs:
      - hw
    files:
      - hw/fetch_pkg.sv
      - hw/axil_fetch_port.sv
      - hw/instr_align.sv
      - hw/instr_fetcher.sv
      - hw/fetch_top.sv
  - target: simulation
    include_dirs:
      - hw
    files:
      - tb/axil_rom_model.sv
      - tb/tb_fetch_top.sv
